//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hazard_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM):
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
common/rv32i_ooo_pkg.sv
common/hazard_ctrl_pkg.sv
ooo_hazard/ooo_hazard_unit.sv
ooo_hazard/reg_scoreboard.sv
completion_buffer/completion_buffer.sv
rtl/prv_exception_ctrl.sv
rtl/hazard_subsystem_top.sv
+incdir+tb
tb/hazard_tb.sv

//--- common/hazard_ctrl_pkg.sv
package hazard_ctrl_pkg;

  // instruction sitting in decode
  typedef struct packed {
    logic                      valid;
    rv32i_ooo_pkg::fu_type_t   fu_type;
    rv32i_ooo_pkg::src_sel_t   source_a_sel;
    rv32i_ooo_pkg::src_sel_t   source_b_sel;
    rv32i_ooo_pkg::reg_idx_t   rs1;
    rv32i_ooo_pkg::reg_idx_t   rs2;
    rv32i_ooo_pkg::reg_idx_t   rd;
    logic                      wen;
    // csr access, serializes the pipe
    logic                      csr;
    logic [31:0]               pc;
  } decode_info_t;

  // long-latency unit occupancy levels
  typedef struct packed {
    logic busy_du;
    logic busy_ls;
  } unit_busy_t;

  // stall and flush levels to the pipeline latches
  typedef struct packed {
    logic pc_en;
    logic stall_fetch_decode;
    logic stall_ex;
    logic fetch_decode_flush;
    logic decode_execute_flush;
    logic execute_commit_flush;
    logic loadstore_flush;
  } hazard_ctrl_t;

  // writeback strobe from a functional unit
  typedef struct packed {
    logic                      valid;
    rv32i_ooo_pkg::reg_idx_t   rd;
    logic                      wen;
    // buffer slot handed out at dispatch
    rv32i_ooo_pkg::cb_idx_t    cb_idx;
  } wb_req_t;

  // exception raised alongside a writeback
  typedef struct packed {
    logic                      valid;
    rv32i_ooo_pkg::exc_cause_t cause;
    logic [31:0]               badaddr;
  } exc_report_t;

  // completion buffer state seen by hazard and privilege logic
  typedef struct packed {
    logic                      full;
    logic                      empty;
    // one cycle, head entry faulted
    logic                      flush;
    logic [31:0]               epc;
    rv32i_ooo_pkg::exc_cause_t cause;
  } cb_status_t;

endpackage

//--- common/rv32i_ooo_pkg.sv
package rv32i_ooo_pkg;

  // register file geometry
  localparam int REG_W    = 5;
  localparam int NUM_REGS = 2 ** REG_W;

  // completion buffer geometry
  localparam int CB_DEPTH = 8;
  localparam int CB_IDX_W = 3;
  // count has to reach CB_DEPTH itself
  localparam int CB_CNT_W = CB_IDX_W + 1;

  // fixed machine-mode handler address
  localparam logic [31:0] TRAP_VECTOR = 32'h0000_0200;

  typedef logic [REG_W-1:0]    reg_idx_t;
  typedef logic [CB_IDX_W-1:0] cb_idx_t;
  typedef logic [CB_CNT_W-1:0] cb_cnt_t;

  // target functional unit of the decoded instruction
  typedef enum logic [1:0] {
    ARITH_S     = 2'd0,
    MUL_S       = 2'd1,
    DIV_S       = 2'd2,
    LOADSTORE_S = 2'd3
  } fu_type_t;

  // operand source select
  // SRC_RS and SRC_RS_ST both read the register file
  // SRC_RS_ST on source a marks a store
  typedef enum logic [1:0] {
    SRC_RS    = 2'd0,
    SRC_RS_ST = 2'd1,
    SRC_IMM   = 2'd2,
    SRC_PC    = 2'd3
  } src_sel_t;

  // trap cause, EXC_NONE means a clean completion
  typedef enum logic [3:0] {
    EXC_NONE       = 4'd0,
    EXC_MAL_INSN   = 4'd1,
    EXC_FAULT_INSN = 4'd2,
    EXC_ILLEGAL    = 4'd3,
    EXC_BREAK      = 4'd4,
    EXC_MAL_L      = 4'd5,
    EXC_FAULT_L    = 4'd6,
    EXC_MAL_S      = 4'd7,
    EXC_FAULT_S    = 4'd8,
    EXC_ENV_M      = 4'd9
  } exc_cause_t;

endpackage

//--- completion_buffer/completion_buffer.sv
module completion_buffer (
  input  logic                          CLK,
  input  logic                          rst,
  input  hazard_ctrl_pkg::decode_info_t dec,
  input  logic                          dispatch,
  input  hazard_ctrl_pkg::wb_req_t      wb,
  input  hazard_ctrl_pkg::exc_report_t  exc,
  output hazard_ctrl_pkg::cb_status_t   status,
  output rv32i_ooo_pkg::cb_idx_t        tail_idx,
  output logic                          commit_valid,
  output rv32i_ooo_pkg::reg_idx_t       commit_rd
);

  // per-entry payload
  typedef struct packed {
    rv32i_ooo_pkg::reg_idx_t   rd;
    logic                      wen;
    logic [31:0]               pc;
    rv32i_ooo_pkg::exc_cause_t cause;
  } cb_entry_t;

  cb_entry_t entry_q [rv32i_ooo_pkg::CB_DEPTH];

  logic [rv32i_ooo_pkg::CB_DEPTH-1:0] valid_q;
  logic [rv32i_ooo_pkg::CB_DEPTH-1:0] done_q;

  rv32i_ooo_pkg::cb_idx_t head_q;
  rv32i_ooo_pkg::cb_idx_t tail_q;
  rv32i_ooo_pkg::cb_cnt_t count_q;

  logic head_ready;
  logic head_exc;
  logic head_flush;

  // head retires once done, faults instead if it carries a cause
  assign head_ready   = valid_q[head_q] & done_q[head_q];
  assign head_exc     = entry_q[head_q].cause != rv32i_ooo_pkg::EXC_NONE;
  assign commit_valid = head_ready & ~head_exc;
  assign head_flush   = head_ready & head_exc;

  // rd of zero when the entry has no destination
  assign commit_rd = entry_q[head_q].wen ? entry_q[head_q].rd : '0;
  assign tail_idx  = tail_q;

  always_comb begin
    status.full  = count_q == rv32i_ooo_pkg::cb_cnt_t'(rv32i_ooo_pkg::CB_DEPTH);
    status.empty = count_q == '0;
    status.flush = head_flush;
    status.epc   = entry_q[head_q].pc;
    status.cause = entry_q[head_q].cause;
  end

  // payload array
  always_ff @(posedge CLK) begin
    if (dispatch) begin
      entry_q[tail_q].rd  <= dec.rd;
      entry_q[tail_q].wen <= dec.wen;
      entry_q[tail_q].pc  <= dec.pc;
    end
    // cause only written at writeback, read only once done
    if (wb.valid) begin
      entry_q[wb.cb_idx].cause <= exc.valid ? exc.cause : rv32i_ooo_pkg::EXC_NONE;
    end
  end

  // pointers, occupancy and entry flags
  always_ff @(posedge CLK) begin
    if (rst || head_flush) begin
      // a faulting head drops everything younger too
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (dispatch) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= rv32i_ooo_pkg::cb_idx_t'(tail_q + 1);
      end
      if (wb.valid) begin
        done_q[wb.cb_idx] <= 1'b1;
      end
      if (commit_valid) begin
        valid_q[head_q] <= 1'b0;
        done_q[head_q]  <= 1'b0;
        head_q          <= rv32i_ooo_pkg::cb_idx_t'(head_q + 1);
      end
      case ({dispatch, commit_valid})
        2'b10:   count_q <= rv32i_ooo_pkg::cb_cnt_t'(count_q + 1);
        2'b01:   count_q <= rv32i_ooo_pkg::cb_cnt_t'(count_q - 1);
        default: count_q <= count_q;
      endcase
    end
  end

  // count stays in range and agrees with the live entries
  no_overflow : assert property (
    @(posedge CLK) disable iff (rst)
    (count_q <= rv32i_ooo_pkg::CB_DEPTH) && (count_q == $countones(valid_q))
  );

  // a unit only writes back slots that were handed out
  wb_hits_valid_entry : assert property (
    @(posedge CLK) disable iff (rst || head_flush)
    wb.valid |-> valid_q[wb.cb_idx]
  );

endmodule

//--- ooo_hazard/ooo_hazard_unit.sv
module ooo_hazard_unit (
  input  logic                         CLK,
  input  logic                         rst,
  input  hazard_ctrl_pkg::decode_info_t dec,
  input  hazard_ctrl_pkg::unit_busy_t   busy,
  input  logic                         i_mem_busy,
  input  logic                         mispredict,
  input  logic                         rs1_busy,
  input  logic                         rs2_busy,
  input  logic                         rd_busy,
  input  hazard_ctrl_pkg::cb_status_t   cb,
  input  logic                         insert_pc,
  output hazard_ctrl_pkg::hazard_ctrl_t ctrl,
  output logic                         dispatch
);

  logic src_a_busy;
  logic src_b_busy;
  logic dst_busy;
  logic data_hazard;
  logic structural_hazard;
  logic store;
  logic store_wait;
  logic front_flush;

  // source only matters when it actually reads the register file
  always_comb begin
    case (dec.source_a_sel)
      rv32i_ooo_pkg::SRC_RS,
      rv32i_ooo_pkg::SRC_RS_ST: src_a_busy = rs1_busy;
      default:                  src_a_busy = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.source_b_sel)
      rv32i_ooo_pkg::SRC_RS,
      rv32i_ooo_pkg::SRC_RS_ST: src_b_busy = rs2_busy;
      default:                  src_b_busy = 1'b0;
    endcase
  end

  // waw, only when this instruction writes back
  assign dst_busy = rd_busy & dec.wen;

  assign data_hazard = src_a_busy | src_b_busy | dst_busy;

  // busy unit blocks only instructions aimed at it
  assign structural_hazard =
    ((dec.fu_type == rv32i_ooo_pkg::DIV_S) & busy.busy_du) |
    ((dec.fu_type == rv32i_ooo_pkg::LOADSTORE_S) & busy.busy_ls);

  // stores go out in order, wait for everything older to retire
  assign store = (dec.fu_type == rv32i_ooo_pkg::LOADSTORE_S) &&
                 (dec.source_a_sel == rv32i_ooo_pkg::SRC_RS_ST);
  assign store_wait = store & ~cb.empty;

  // redirect from a mispredict, a trap insertion or a faulting commit
  assign front_flush = mispredict | insert_pc | cb.flush;

  always_comb begin
    ctrl.stall_ex           = cb.full;
    // csr always holds decode
    ctrl.stall_fetch_decode = data_hazard | structural_hazard | store_wait |
                              cb.full | dec.csr;
    ctrl.pc_en              = ~(i_mem_busy | ctrl.stall_fetch_decode);

    ctrl.fetch_decode_flush   = front_flush;
    ctrl.decode_execute_flush = front_flush;
    // back end only cleared by the buffer itself
    ctrl.execute_commit_flush = cb.flush;
    ctrl.loadstore_flush      = cb.flush;
  end

  // shared strobe, scoreboard and buffer do not re-test the stall
  assign dispatch = dec.valid & ~ctrl.stall_fetch_decode & ~front_flush;

  // an accepted instruction must show up in the buffer
  dispatch_lands_in_buffer : assert property (
    @(posedge CLK) disable iff (rst)
    dispatch |=> !cb.empty
  );

  // trap insertion follows a flush, so the buffer has already emptied
  insert_on_empty_buffer : assert property (
    @(posedge CLK) disable iff (rst)
    insert_pc |-> cb.empty
  );

endmodule

//--- ooo_hazard/reg_scoreboard.sv
module reg_scoreboard (
  input  logic                          CLK,
  input  logic                          rst,
  input  hazard_ctrl_pkg::decode_info_t dec,
  input  logic                          dispatch,
  input  hazard_ctrl_pkg::wb_req_t      wb,
  input  logic                          flush,
  output logic                          rs1_busy,
  output logic                          rs2_busy,
  output logic                          rd_busy
);

  logic [rv32i_ooo_pkg::NUM_REGS-1:0] busy_q;
  logic [rv32i_ooo_pkg::NUM_REGS-1:0] set_mask;
  logic [rv32i_ooo_pkg::NUM_REGS-1:0] clr_mask;

  // x0 never gets marked
  always_comb begin
    set_mask = '0;
    if (dispatch && dec.wen && (dec.rd != '0)) begin
      set_mask[dec.rd] = 1'b1;
    end
  end

  always_comb begin
    clr_mask = '0;
    if (wb.valid && wb.wen) begin
      clr_mask[wb.rd] = 1'b1;
    end
  end

  // set applied after clear, so a same-cycle set wins
  always_ff @(posedge CLK) begin
    if (rst) begin
      busy_q <= '0;
    end else if (flush) begin
      // all in-flight writers are gone
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~clr_mask) | set_mask;
    end
  end

  // lookups for the decode fields
  assign rs1_busy = busy_q[dec.rs1];
  assign rs2_busy = busy_q[dec.rs2];
  assign rd_busy  = busy_q[dec.rd];

  // writer must have been dispatched and not yet flushed
  wb_targets_busy_reg : assert property (
    @(posedge CLK) disable iff (rst || flush)
    (wb.valid && wb.wen && (wb.rd != '0)) |-> busy_q[wb.rd]
  );

endmodule

//--- rtl/hazard_subsystem_top.sv
module hazard_subsystem_top (
  input  logic                          CLK,
  input  logic                          rst,
  input  hazard_ctrl_pkg::decode_info_t dec,
  input  hazard_ctrl_pkg::unit_busy_t   busy,
  input  logic                          i_mem_busy,
  input  logic                          mispredict,
  input  hazard_ctrl_pkg::wb_req_t      wb,
  input  hazard_ctrl_pkg::exc_report_t  exc,
  output hazard_ctrl_pkg::hazard_ctrl_t ctrl,
  output rv32i_ooo_pkg::cb_idx_t        cb_idx,
  output logic                          commit_valid,
  output rv32i_ooo_pkg::reg_idx_t       commit_rd,
  output logic                          insert_pc,
  output logic [31:0]                   priv_pc,
  output rv32i_ooo_pkg::exc_cause_t     cause_q,
  output logic [31:0]                   epc_q
);

  logic                        rs1_busy;
  logic                        rs2_busy;
  logic                        rd_busy;
  logic                        dispatch;
  hazard_ctrl_pkg::cb_status_t cb_status;

  ooo_hazard_unit u_hazard (
    .CLK        (CLK),
    .rst        (rst),
    .dec        (dec),
    .busy       (busy),
    .i_mem_busy (i_mem_busy),
    .mispredict (mispredict),
    .rs1_busy   (rs1_busy),
    .rs2_busy   (rs2_busy),
    .rd_busy    (rd_busy),
    .cb         (cb_status),
    .insert_pc  (insert_pc),
    .ctrl       (ctrl),
    .dispatch   (dispatch)
  );

  // cleared by the buffer flush only
  reg_scoreboard u_scoreboard (
    .CLK      (CLK),
    .rst      (rst),
    .dec      (dec),
    .dispatch (dispatch),
    .wb       (wb),
    .flush    (cb_status.flush),
    .rs1_busy (rs1_busy),
    .rs2_busy (rs2_busy),
    .rd_busy  (rd_busy)
  );

  completion_buffer u_cb (
    .CLK          (CLK),
    .rst          (rst),
    .dec          (dec),
    .dispatch     (dispatch),
    .wb           (wb),
    .exc          (exc),
    .status       (cb_status),
    .tail_idx     (cb_idx),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd)
  );

  prv_exception_ctrl u_prv (
    .CLK       (CLK),
    .rst       (rst),
    .cb        (cb_status),
    .insert_pc (insert_pc),
    .priv_pc   (priv_pc),
    .cause_q   (cause_q),
    .epc_q     (epc_q)
  );

endmodule

//--- rtl/prv_exception_ctrl.sv
module prv_exception_ctrl (
  input  logic                        CLK,
  input  logic                        rst,
  input  hazard_ctrl_pkg::cb_status_t cb,
  output logic                        insert_pc,
  output logic [31:0]                 priv_pc,
  output rv32i_ooo_pkg::exc_cause_t   cause_q,
  output logic [31:0]                 epc_q
);

  logic insert_q;

  // one-cycle redirect right after the faulting commit
  always_ff @(posedge CLK) begin
    if (rst) begin
      insert_q <= 1'b0;
    end else begin
      insert_q <= cb.flush;
    end
  end

  // last trap kept for observation
  always_ff @(posedge CLK) begin
    if (rst) begin
      cause_q <= rv32i_ooo_pkg::EXC_NONE;
      epc_q   <= '0;
    end else if (cb.flush) begin
      cause_q <= cb.cause;
      epc_q   <= cb.epc;
    end
  end

  assign insert_pc = insert_q;
  // single handler, no vectored mode
  assign priv_pc   = rv32i_ooo_pkg::TRAP_VECTOR;

  // buffer is empty after a flush, so the redirect cannot repeat
  insert_one_cycle : assert property (
    @(posedge CLK) disable iff (rst)
    insert_pc |=> !insert_pc
  );

endmodule

//--- tb/hazard_model.svh
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

// mirrored busy vector, updated with the same stimulus the DUT sees
logic [rv32i_ooo_pkg::NUM_REGS-1:0] m_busy;

// mirrored buffer slots
logic                      m_valid [rv32i_ooo_pkg::CB_DEPTH];
logic                      m_done  [rv32i_ooo_pkg::CB_DEPTH];
rv32i_ooo_pkg::reg_idx_t   m_rd    [rv32i_ooo_pkg::CB_DEPTH];
logic                      m_wen   [rv32i_ooo_pkg::CB_DEPTH];
logic [31:0]               m_pc    [rv32i_ooo_pkg::CB_DEPTH];
rv32i_ooo_pkg::exc_cause_t m_cause [rv32i_ooo_pkg::CB_DEPTH];
int                        m_head;
int                        m_tail;
int                        m_count;

// trap side
logic                      m_insert;
rv32i_ooo_pkg::exc_cause_t m_trap_cause;
logic [31:0]               m_trap_epc;

task automatic fail_run(input string msg);
  $display("%s", msg);
  $display("TESTS FAILED");
  $fatal(1, "simulation stopped on first error");
endtask

function automatic logic reads_reg(input rv32i_ooo_pkg::src_sel_t sel);
  return (sel == rv32i_ooo_pkg::SRC_RS) || (sel == rv32i_ooo_pkg::SRC_RS_ST);
endfunction

// expected stall and flush levels from the mirror
function automatic hazard_ctrl_pkg::hazard_ctrl_t ref_ctrl(
  input hazard_ctrl_pkg::decode_info_t d,
  input hazard_ctrl_pkg::unit_busy_t   u,
  input logic                          imem,
  input logic                          mp,
  input logic                          flush
);
  hazard_ctrl_pkg::hazard_ctrl_t c;
  logic raw;
  logic struct_h;
  logic st_wait;
  logic front;
  raw = (reads_reg(d.source_a_sel) && m_busy[d.rs1]) ||
        (reads_reg(d.source_b_sel) && m_busy[d.rs2]) ||
        (d.wen && m_busy[d.rd]);
  struct_h = ((d.fu_type == rv32i_ooo_pkg::DIV_S) && u.busy_du) ||
             ((d.fu_type == rv32i_ooo_pkg::LOADSTORE_S) && u.busy_ls);
  // store only leaves decode with an empty buffer
  st_wait = (d.fu_type == rv32i_ooo_pkg::LOADSTORE_S) &&
            (d.source_a_sel == rv32i_ooo_pkg::SRC_RS_ST) && (m_count != 0);
  front = mp || m_insert || flush;
  c.stall_ex             = (m_count == rv32i_ooo_pkg::CB_DEPTH);
  c.stall_fetch_decode   = raw || struct_h || st_wait || c.stall_ex || d.csr;
  c.pc_en                = !(imem || c.stall_fetch_decode);
  c.fetch_decode_flush   = front;
  c.decode_execute_flush = front;
  c.execute_commit_flush = flush;
  c.loadstore_flush      = flush;
  return c;
endfunction

function automatic logic head_faults();
  return m_valid[m_head] && m_done[m_head] && (m_cause[m_head] != rv32i_ooo_pkg::EXC_NONE);
endfunction

function automatic logic head_commits();
  return m_valid[m_head] && m_done[m_head] && (m_cause[m_head] == rv32i_ooo_pkg::EXC_NONE);
endfunction

task automatic reset_mirror();
  m_busy = '0;
  for (int i = 0; i < rv32i_ooo_pkg::CB_DEPTH; i++) begin
    m_valid[i] = 1'b0;
    m_done[i]  = 1'b0;
    m_cause[i] = rv32i_ooo_pkg::EXC_NONE;
  end
  m_head  = 0;
  m_tail  = 0;
  m_count = 0;
endtask

task automatic check_ctrl(
  input hazard_ctrl_pkg::hazard_ctrl_t exp_c,
  input hazard_ctrl_pkg::hazard_ctrl_t got_c
);
  if (got_c !== exp_c) begin
    fail_run($sformatf("** Error at %0t: ctrl expected %b got %b", $time, exp_c, got_c));
  end
endtask

task automatic check_commit(
  input logic                    exp_v,
  input rv32i_ooo_pkg::reg_idx_t exp_rd,
  input logic                    got_v,
  input rv32i_ooo_pkg::reg_idx_t got_rd
);
  if ((got_v !== exp_v) || (exp_v && (got_rd !== exp_rd))) begin
    fail_run($sformatf("** Error at %0t: commit expected %b/x%0d got %b/x%0d",
                       $time, exp_v, exp_rd, got_v, got_rd));
  end
endtask

task automatic check_trap(
  input rv32i_ooo_pkg::exc_cause_t exp_cause,
  input logic [31:0]               exp_epc,
  input rv32i_ooo_pkg::exc_cause_t got_cause,
  input logic [31:0]               got_epc
);
  if ((got_cause !== exp_cause) || (got_epc !== exp_epc)) begin
    fail_run($sformatf("** Error at %0t: trap expected %s/%h got %s/%h",
                       $time, exp_cause.name(), exp_epc, got_cause.name(), got_epc));
  end
endtask

`endif

//--- tb/hazard_tb.sv
module hazard_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int D = rv32i_ooo_pkg::CB_DEPTH;
  localparam int TMO = 200;

  logic                          CLK;
  logic                          rst;
  hazard_ctrl_pkg::decode_info_t dec;
  hazard_ctrl_pkg::unit_busy_t   busy;
  logic                          i_mem_busy;
  logic                          mispredict;
  hazard_ctrl_pkg::wb_req_t      wb;
  hazard_ctrl_pkg::exc_report_t  exc;
  hazard_ctrl_pkg::hazard_ctrl_t ctrl;
  rv32i_ooo_pkg::cb_idx_t        cb_idx;
  logic                          commit_valid;
  rv32i_ooo_pkg::reg_idx_t       commit_rd;
  logic                          insert_pc;
  logic [31:0]                   priv_pc;
  rv32i_ooo_pkg::exc_cause_t     cause_q;
  logic [31:0]                   epc_q;

  `include "hazard_model.svh"

  hazard_subsystem_top dut_i (.*);

  always #20 CLK = ~CLK;

  // compare before the edge, then advance the mirror
  always @(negedge CLK) begin
    hazard_ctrl_pkg::hazard_ctrl_t exp_c;
    logic exp_flush;
    logic exp_commit;
    logic exp_disp;
    if (rst) begin
      reset_mirror();
      m_insert     = 1'b0;
      m_trap_cause = rv32i_ooo_pkg::EXC_NONE;
      m_trap_epc   = '0;
    end else begin
      exp_flush  = head_faults();
      exp_commit = head_commits();
      exp_c = ref_ctrl(dec, busy, i_mem_busy, mispredict, exp_flush);
      check_ctrl(exp_c, ctrl);
      check_commit(exp_commit, m_wen[m_head] ? m_rd[m_head] : '0, commit_valid, commit_rd);
      check_trap(m_trap_cause, m_trap_epc, cause_q, epc_q);
      // redirect goes to the fixed handler for one cycle
      if ((insert_pc !== m_insert) || (m_insert && (priv_pc !== rv32i_ooo_pkg::TRAP_VECTOR))) begin
        fail_run($sformatf("** Error at %0t: insert_pc expected %b got %b pc %h",
                           $time, m_insert, insert_pc, priv_pc));
      end
      exp_disp = dec.valid && !exp_c.stall_fetch_decode && !exp_c.fetch_decode_flush;
      if (exp_disp && (cb_idx !== rv32i_ooo_pkg::cb_idx_t'(m_tail))) begin
        fail_run($sformatf("** Error at %0t: tail index expected %0d got %0d",
                           $time, m_tail, cb_idx));
      end
      if (exp_flush) begin
        m_trap_cause = m_cause[m_head];
        m_trap_epc   = m_pc[m_head];
        reset_mirror();
      end else begin
        // clear first so a same-cycle set wins
        if (wb.valid && wb.wen) m_busy[wb.rd] = 1'b0;
        if (exp_disp && dec.wen && (dec.rd != '0)) m_busy[dec.rd] = 1'b1;
        if (wb.valid) begin
          m_done[wb.cb_idx]  = 1'b1;
          m_cause[wb.cb_idx] = exc.valid ? exc.cause : rv32i_ooo_pkg::EXC_NONE;
        end
        if (exp_commit) begin
          m_valid[m_head] = 1'b0;
          m_head  = (m_head + 1) % D;
          m_count = m_count - 1;
        end
        if (exp_disp) begin
          m_valid[m_tail] = 1'b1;
          m_done[m_tail]  = 1'b0;
          m_rd[m_tail]    = dec.rd;
          m_wen[m_tail]   = dec.wen;
          m_pc[m_tail]    = dec.pc;
          m_tail  = (m_tail + 1) % D;
          m_count = m_count + 1;
        end
      end
      m_insert = exp_flush;
    end
  end

  // writeback for a random pending slot, optionally faulting
  task automatic drive_wb(input bit allow_exc);
    int start;
    int slot;
    slot  = -1;
    start = $urandom_range(0, D - 1);
    wb    = '0;
    exc   = '0;
    for (int i = 0; i < D; i++) begin
      if ((slot < 0) && m_valid[(start + i) % D] && !m_done[(start + i) % D]) begin
        slot = (start + i) % D;
      end
    end
    if (slot >= 0) begin
      wb.valid  = 1'b1;
      wb.rd     = m_rd[slot];
      wb.wen    = m_wen[slot];
      wb.cb_idx = rv32i_ooo_pkg::cb_idx_t'(slot);
      if (allow_exc && ($urandom_range(0, 11) == 0)) begin
        exc.valid   = 1'b1;
        exc.cause   = rv32i_ooo_pkg::exc_cause_t'($urandom_range(1, 9));
        exc.badaddr = $urandom;
      end
    end
  endtask

  // mode 0 random traffic, 1 fill with plain ops, 2 drain
  task automatic step(input int mode);
    @(posedge CLK);
    #2;
    dec        = '0;
    dec.pc     = $urandom & 32'hffff_fffc;
    i_mem_busy = ($urandom_range(0, 9) == 0);
    busy       = '0;
    mispredict = 1'b0;
    wb         = '0;
    exc        = '0;
    if (mode == 0) begin
      // small register range so hazards show up often
      dec.valid        = ($urandom_range(0, 4) != 0);
      dec.fu_type      = rv32i_ooo_pkg::fu_type_t'($urandom_range(0, 3));
      dec.source_a_sel = rv32i_ooo_pkg::src_sel_t'($urandom_range(0, 3));
      dec.source_b_sel = rv32i_ooo_pkg::src_sel_t'($urandom_range(0, 3));
      dec.rs1          = rv32i_ooo_pkg::reg_idx_t'($urandom_range(0, 7));
      dec.rs2          = rv32i_ooo_pkg::reg_idx_t'($urandom_range(0, 7));
      dec.rd           = rv32i_ooo_pkg::reg_idx_t'($urandom_range(0, 7));
      dec.wen          = ($urandom_range(0, 9) < 7);
      dec.csr          = ($urandom_range(0, 29) == 0);
      busy.busy_du     = ($urandom_range(0, 4) == 0);
      busy.busy_ls     = ($urandom_range(0, 4) == 0);
      mispredict       = ($urandom_range(0, 29) == 0);
      if ($urandom_range(0, 1) == 1) drive_wb(1'b1);
    end else if (mode == 1) begin
      dec.valid        = 1'b1;
      dec.fu_type      = rv32i_ooo_pkg::ARITH_S;
      dec.source_a_sel = rv32i_ooo_pkg::SRC_IMM;
      dec.source_b_sel = rv32i_ooo_pkg::SRC_PC;
      // distinct rd per slot so retire order is visible
      dec.rd           = rv32i_ooo_pkg::reg_idx_t'(m_tail + 1);
      dec.wen          = 1'b1;
    end else begin
      drive_wb(1'b0);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((m_count != 0) && (n < TMO)) begin
      step(2);
      n++;
    end
    if (m_count != 0) fail_run("timeout: completion buffer did not drain");
  endtask

  task automatic fill();
    int n;
    n = 0;
    while ((m_count != D) && (n < TMO)) begin
      step(1);
      n++;
    end
    if (m_count != D) fail_run("timeout: completion buffer did not fill");
  endtask

  initial begin
    void'($urandom(32'h6dd80470));
    CLK         = 1'b0;
    rst         = 1'b1;
    dec         = '0;
    busy        = '0;
    i_mem_busy  = 1'b0;
    mispredict  = 1'b0;
    wb          = '0;
    exc         = '0;
    repeat (4) @(posedge CLK);
    #2;
    rst = 1'b0;
    repeat (20) step(2);
    repeat (1500) step(0);
    drain();
    // full buffer holds decode, then retire in dispatch order
    fill();
    repeat (4) step(1);
    drain();
    repeat (1000) step(0);
    drain();
    repeat (4) step(2);
    $display("TESTS PASSED");
    $finish;
  end

endmodule
